// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
LINTFLAGS = --lint-only --timing
TOP = tbVideoMem
FILELIST = filelist.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_TEXT = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cpuBusDecoder.sv
// CPU bus decode and read select

`timescale 1ns/1ps

module cpuBusDecoder (
	input  logic                                    clk0,
	input  logic                                    reset,
	input  logic [memMapPkg::cpuAddrWidth-1:0]      cpuAddr,
	input  logic [memMapPkg::dataWidth-1:0]         cpuWriteData,
	input  logic                                    cpuWrite,
	input  logic                                    cpuRead,
	input  logic                                    busy,
	input  logic [memMapPkg::vramWordAddrWidth-1:0] wordAddr,
	output logic [memMapPkg::vramWordWidth-1:0]     wordData,
	output logic [memMapPkg::dataWidth-1:0]         cpuReadData
);

	logic [memMapPkg::cpuAddrWidth-1:0] vramOffset;
	logic                               vramHit;
	logic                               statusHit;
	logic [memMapPkg::dataWidth-1:0]    vramReadData;
	logic [memMapPkg::dataWidth-1:0]    statusByte;
	logic [memMapPkg::dataWidth-1:0]    selectedData;
	logic                               selVram;
	logic                               selStatus;
	logic                               readValid;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	assign vramOffset = cpuAddr - memMapPkg::vramBase;
	assign vramHit = (int'(vramOffset) < memMapPkg::vramBytes);
	assign statusHit = (cpuAddr == memMapPkg::statusAddr);

	splitVram vram (
		.clk0         (clk0),
		.reset        (reset),
		.cpuAddr      (vramOffset[memMapPkg::vramWordAddrWidth:0]),
		.cpuWriteData (cpuWriteData),
		.cpuWrite     (cpuWrite & vramHit),
		.cpuReadData  (vramReadData),
		.wordAddr     (wordAddr),
		.wordData     (wordData)
	);

	// Source of the pending read, plus busy sampled with it
	always_ff @(posedge clk0) begin
		if (reset) begin
			readValid <= 1'b0;
			selVram <= 1'b0;
			selStatus <= 1'b0;
			statusByte <= '0;
		end else if (cpuRead) begin
			readValid <= 1'b1;
			selVram <= vramHit;
			selStatus <= statusHit;
			statusByte <= {{(memMapPkg::dataWidth-1){1'b0}}, busy};
		end
	end

	// ----------------------------------------
	// Read data priority select
	// ----------------------------------------
	assign selectedData = selVram ? vramReadData :
		selStatus ? statusByte :
		memMapPkg::unmappedData;

	// Nothing read since reset
	assign cpuReadData = readValid ? selectedData : '0;

endmodule

// File: dualPortRam.sv
// Byte-wide dual port RAM

`timescale 1ns/1ps

module dualPortRam #(
	parameter int addrWidth = 10
) (
	input  logic                            clk0,
	input  logic [addrWidth-1:0]            aAddr,
	input  logic [memMapPkg::dataWidth-1:0] aWriteData,
	input  logic                            aWrite,
	output logic [memMapPkg::dataWidth-1:0] aReadData,
	input  logic [addrWidth-1:0]            bAddr,
	output logic [memMapPkg::dataWidth-1:0] bReadData
);

	logic [memMapPkg::dataWidth-1:0] mem [0:(1 << addrWidth)-1];

	// Port A, a write cycle does not update the read register
	always_ff @(posedge clk0) begin
		if (aWrite) begin
			mem[aAddr] <= aWriteData;
		end else begin
			aReadData <= mem[aAddr];
		end
	end

	// Port B reads every cycle
	always_ff @(posedge clk0) begin
		bReadData <= mem[bAddr];
	end

endmodule

// File: filelist.f
memMapPkg.sv
videoPkg.sv
dualPortRam.sv
splitVram.sv
lineBuffer.sv
lineRenderer.sv
cpuBusDecoder.sv
videoMemTop.sv
videoMem_sva.sv
tbVideoMem.sv

// File: lineBuffer.sv
// Clear-on-read scan line buffer

`timescale 1ns/1ps

module lineBuffer (
	input  logic                              clk0,
	input  logic                              reset,
	input  logic [videoPkg::lineAddrWidth-1:0] writeAddr,
	input  logic [videoPkg::pixelWidth-1:0]    writePixel,
	input  logic                              write,
	input  logic [videoPkg::lineAddrWidth-1:0] scanAddr,
	input  logic                              scanRead,
	output logic [videoPkg::pixelWidth-1:0]    scanPixel
);

	logic [videoPkg::pixelWidth-1:0] lineMem [0:videoPkg::lineLength-1];

	// ----------------------------------------
	// Storage
	// ----------------------------------------
	// Render side fills, scan side wipes what it has shown
	// Both never hit one address in the same cycle
	always_ff @(posedge clk0) begin
		if (write) begin
			lineMem[writeAddr] <= writePixel;
		end
		if (scanRead) begin
			lineMem[scanAddr] <= '0;
		end
	end

	// ----------------------------------------
	// Scan output
	// ----------------------------------------
	// Holds last pixel between reads
	always_ff @(posedge clk0) begin
		if (reset) begin
			scanPixel <= '0;
		end else if (scanRead) begin
			scanPixel <= lineMem[scanAddr];
		end
	end

endmodule

// File: lineRenderer.sv
// Tile line renderer

`timescale 1ns/1ps

module lineRenderer (
	input  logic                                    clk0,
	input  logic                                    reset,
	input  logic                                    lineStart,
	input  logic [videoPkg::lineNumberWidth-1:0]    lineNumber,
	output logic [memMapPkg::vramWordAddrWidth-1:0] vramWordAddr,
	input  logic [memMapPkg::vramWordWidth-1:0]     vramWord,
	output logic [memMapPkg::romAddrWidth-1:0]      romAddr,
	input  logic [memMapPkg::dataWidth-1:0]         romByte,
	output logic [videoPkg::lineAddrWidth-1:0]      pixelAddr,
	output logic [videoPkg::pixelWidth-1:0]         pixel,
	output logic                                    pixelWrite,
	output logic                                    busy,
	output logic                                    renderDone
);

	typedef enum logic [1:0] {
		stateIdle,
		stateWord,
		stateRow,
		statePixels
	} stateT;

	stateT                                   state;
	logic [videoPkg::columnBits-1:0]         column;
	logic [videoPkg::tileBits-1:0]           pixelCount;
	logic [videoPkg::lineNumberWidth-1:0]    lineNum;
	logic [videoPkg::paletteWidth-1:0]       palette;
	logic [memMapPkg::dataWidth-1:0]         rowShift;
	logic                                    pixelBit;

	// ----------------------------------------
	// Sequencer
	// ----------------------------------------
	// Per column: word fetch, ROM fetch, then eight pixel writes
	always_ff @(posedge clk0) begin
		if (reset) begin
			state <= stateIdle;
			column <= '0;
			pixelCount <= '0;
			renderDone <= 1'b0;
		end else begin
			renderDone <= 1'b0;
			case (state)
				stateIdle: begin
					if (lineStart) begin
						state <= stateWord;
						column <= '0;
						pixelCount <= '0;
					end
				end
				stateWord: state <= stateRow;
				stateRow: state <= statePixels;
				statePixels: begin
					pixelCount <= pixelCount + 1'b1;
					if (int'(pixelCount) == videoPkg::tileSize - 1) begin
						column <= column + 1'b1;
						if (int'(column) == videoPkg::tilesPerRow - 1) begin
							state <= stateIdle;
							renderDone <= 1'b1;
						end else begin
							state <= stateWord;
						end
					end
				end
				default: state <= stateIdle;
			endcase
		end
	end

	// Line number, palette and ROM row
	always_ff @(posedge clk0) begin
		if (state == stateIdle && lineStart) begin
			lineNum <= lineNumber;
		end
		if (state == stateRow) begin
			palette <= vramWord[memMapPkg::dataWidth +: videoPkg::paletteWidth];
		end
		if (pixelWrite) begin
			if (pixelCount == '0) begin
				rowShift <= {romByte[memMapPkg::dataWidth-2:0], 1'b0};
			end else begin
				rowShift <= {rowShift[memMapPkg::dataWidth-2:0], 1'b0};
			end
		end
	end

	// ----------------------------------------
	// Addresses and pixel out
	// ----------------------------------------
	assign vramWordAddr = {lineNum[videoPkg::lineNumberWidth-1:videoPkg::tileBits], column};

	// Tile code picks the tile, low line bits pick its row
	assign romAddr = {vramWord[memMapPkg::dataWidth-1:0], lineNum[videoPkg::tileBits-1:0]};

	// First pixel comes straight off the ROM, MSB is leftmost
	assign pixelBit = (pixelCount == '0) ? romByte[memMapPkg::dataWidth-1]
		: rowShift[memMapPkg::dataWidth-1];

	assign pixel = {palette, pixelBit};
	assign pixelAddr = {column, pixelCount};
	assign pixelWrite = (state == statePixels);
	assign busy = (state != stateIdle);

endmodule

// File: memMapPkg.sv
// CPU memory map definitions

package memMapPkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------
	localparam int cpuAddrWidth = 12;
	localparam int dataWidth = 8;
	localparam int vramWordWidth = 2 * dataWidth;

	// ----------------------------------------
	// Memory depths
	// ----------------------------------------
	localparam int romAddrWidth = 11;
	localparam int vramWordAddrWidth = 10;
	localparam int vramBytes = 2048;

	// ----------------------------------------
	// CPU address map
	// ----------------------------------------
	// VRAM occupies vramBytes bytes from here
	localparam logic [cpuAddrWidth-1:0] vramBase = 12'h000;

	// Renderer status, busy in bit 0
	localparam logic [cpuAddrWidth-1:0] statusAddr = 12'h800;

	// Returned for anything not decoded
	localparam logic [dataWidth-1:0] unmappedData = 8'hFF;

endpackage

// File: splitVram.sv
// Even and odd bank video RAM

`timescale 1ns/1ps

module splitVram (
	input  logic                                    clk0,
	input  logic                                    reset,
	input  logic [memMapPkg::vramWordAddrWidth:0]   cpuAddr,
	input  logic [memMapPkg::dataWidth-1:0]         cpuWriteData,
	input  logic                                    cpuWrite,
	output logic [memMapPkg::dataWidth-1:0]         cpuReadData,
	input  logic [memMapPkg::vramWordAddrWidth-1:0] wordAddr,
	output logic [memMapPkg::vramWordWidth-1:0]     wordData
);

	logic [memMapPkg::dataWidth-1:0] evenCpuByte;
	logic [memMapPkg::dataWidth-1:0] oddCpuByte;
	logic [memMapPkg::dataWidth-1:0] evenWordByte;
	logic [memMapPkg::dataWidth-1:0] oddWordByte;
	logic                            readOdd;

	// ----------------------------------------
	// Banks
	// ----------------------------------------
	// Even bank holds tile codes
	dualPortRam #(
		.addrWidth (memMapPkg::vramWordAddrWidth)
	) evenBank (
		.clk0       (clk0),
		.aAddr      (cpuAddr[memMapPkg::vramWordAddrWidth:1]),
		.aWriteData (cpuWriteData),
		.aWrite     (cpuWrite & ~cpuAddr[0]),
		.aReadData  (evenCpuByte),
		.bAddr      (wordAddr),
		.bReadData  (evenWordByte)
	);

	// Odd bank holds attributes
	dualPortRam #(
		.addrWidth (memMapPkg::vramWordAddrWidth)
	) oddBank (
		.clk0       (clk0),
		.aAddr      (cpuAddr[memMapPkg::vramWordAddrWidth:1]),
		.aWriteData (cpuWriteData),
		.aWrite     (cpuWrite & cpuAddr[0]),
		.aReadData  (oddCpuByte),
		.bAddr      (wordAddr),
		.bReadData  (oddWordByte)
	);

	// ----------------------------------------
	// Byte select
	// ----------------------------------------
	// Banks read on every non-write cycle, so track the byte lane with them
	always_ff @(posedge clk0) begin
		if (reset) begin
			readOdd <= 1'b0;
		end else if (!cpuWrite) begin
			readOdd <= cpuAddr[0];
		end
	end

	assign cpuReadData = readOdd ? oddCpuByte : evenCpuByte;
	assign wordData = {oddWordByte, evenWordByte};

endmodule

// File: tbVideoMem.sv
// Video memory subsystem testbench

`timescale 1ns/1ps

module tbVideoMem;

	localparam int clockPeriod = 20;
	localparam int resetCycles = 5;
	localparam int romBytes = 1 << memMapPkg::romAddrWidth;
	localparam int randomWrites = 64;
	localparam int randomReads = 64;
	localparam int unmappedReads = 16;
	localparam int renderCycles = 330;
	localparam int busCycles = romBytes + memMapPkg::vramBytes + 2 * randomWrites
		+ randomReads + unmappedReads + videoPkg::tilesPerRow + 5 * videoPkg::lineLength;
	localparam int watchdogCycles = 2 * (resetCycles + 4 * renderCycles + busCycles) + 200;

	logic                                 clk0;
	logic                                 reset;
	logic [memMapPkg::cpuAddrWidth-1:0]   cpuAddr;
	logic [memMapPkg::dataWidth-1:0]      cpuWriteData;
	logic                                 cpuWrite;
	logic                                 cpuRead;
	logic [memMapPkg::dataWidth-1:0]      cpuReadData;
	logic [memMapPkg::romAddrWidth-1:0]   romAddr;
	logic [memMapPkg::dataWidth-1:0]      romData;
	logic                                 romWrite;
	logic                                 lineStart;
	logic [videoPkg::lineNumberWidth-1:0] lineNumber;
	logic                                 busy;
	logic                                 renderDone;
	logic [videoPkg::lineAddrWidth-1:0]   scanAddr;
	logic                                 scanRead;
	logic [videoPkg::pixelWidth-1:0]      scanPixel;

	// Reference copies of VRAM bytes and tile ROM
	logic [7:0]  vramModel [0:memMapPkg::vramBytes-1];
	logic [7:0]  romModel [0:romBytes-1];
	logic [31:0] lcgState;
	int          errorCount = 0;
	int          checkCount = 0;
	int          doneCount = 0;

	videoMemTop videoMemTop_inst (
		.clk0         (clk0),
		.reset        (reset),
		.cpuAddr      (cpuAddr),
		.cpuWriteData (cpuWriteData),
		.cpuWrite     (cpuWrite),
		.cpuRead      (cpuRead),
		.cpuReadData  (cpuReadData),
		.romAddr      (romAddr),
		.romData      (romData),
		.romWrite     (romWrite),
		.lineStart    (lineStart),
		.lineNumber   (lineNumber),
		.busy         (busy),
		.renderDone   (renderDone),
		.scanAddr     (scanAddr),
		.scanRead     (scanRead),
		.scanPixel    (scanPixel)
	);

	initial clk0 = 1'b0;
	always #(clockPeriod / 2) clk0 = ~clk0;

	// Every done pulse seen by the bus, counted one edge late
	always @(posedge clk0) begin
		if (renderDone === 1'b1) begin
			doneCount <= doneCount + 1;
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic int randomBelow(input int limit);
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return int'(lcgState[30:16]) % limit;
	endfunction

	// Pixel from the VRAM and ROM layout rules
	function automatic logic [4:0] expectedPixel(input logic [7:0] line, input int x);
		int         word;
		logic [7:0] code;
		logic [7:0] attr;
		logic [7:0] row;
		word = int'(line[7:3]) * videoPkg::tilesPerRow + x / videoPkg::tileSize;
		code = vramModel[2 * word];
		attr = vramModel[2 * word + 1];
		row = romModel[int'(code) * videoPkg::tileSize + int'(line[2:0])];
		return {attr[3:0], row[7 - x % videoPkg::tileSize]};
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic writeVram(input int addr, input logic [7:0] data);
		cpuAddr = 12'(addr);
		cpuWriteData = data;
		cpuWrite = 1'b1;
		@(negedge clk0);
		cpuWrite = 1'b0;
		vramModel[addr] = data;
	endtask

	// Read data is sampled one cycle after the strobe
	task automatic readCheck(input string name, input int addr, input logic [7:0] expected);
		cpuAddr = 12'(addr);
		cpuRead = 1'b1;
		@(negedge clk0);
		cpuRead = 1'b0;
		checkValue(name, 16'(expected), 16'(cpuReadData));
	endtask

	task automatic writeRom(input int addr, input logic [7:0] data);
		romAddr = 11'(addr);
		romData = data;
		romWrite = 1'b1;
		@(negedge clk0);
		romWrite = 1'b0;
		romModel[addr] = data;
	endtask

	task automatic startRender(input logic [7:0] line);
		lineNumber = line;
		lineStart = 1'b1;
		@(negedge clk0);
		lineStart = 1'b0;
	endtask

	task automatic waitDone(input string name);
		int startCount;
		int waited;
		startCount = doneCount;
		waited = 0;
		while (doneCount == startCount && waited < renderCycles) begin
			@(negedge clk0);
			waited++;
		end
		assert (doneCount != startCount) else begin
			errorCount++;
			$display("%s: renderDone did not arrive within %0d cycles", name, renderCycles);
		end
	endtask

	// One read per cycle, expecting blank entries when cleared is set
	task automatic scanLine(input string name, input logic [7:0] line, input logic cleared);
		for (int x = 0; x < videoPkg::lineLength; x++) begin
			scanAddr = 8'(x);
			scanRead = 1'b1;
			@(negedge clk0);
			checkValue($sformatf("%s pixel %0d", name, x),
				cleared ? 16'h0 : 16'(expectedPixel(line, x)), 16'(scanPixel));
		end
		scanRead = 1'b0;
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		int         addr;
		int         word;
		int         startCount;
		logic [7:0] line;
		lcgState = 32'd90;
		reset = 1'b1;
		cpuAddr = '0;
		cpuWriteData = '0;
		cpuWrite = 1'b0;
		cpuRead = 1'b0;
		romAddr = '0;
		romData = '0;
		romWrite = 1'b0;
		lineStart = 1'b0;
		lineNumber = '0;
		scanAddr = '0;
		scanRead = 1'b0;
		repeat (resetCycles) @(negedge clk0);
		reset = 1'b0;
		checkValue("reset busy", 16'h0, 16'(busy));
		checkValue("reset renderDone", 16'h0, 16'(renderDone));
		checkValue("reset scanPixel", 16'h0, 16'(scanPixel));
		checkValue("reset cpuReadData", 16'h0, 16'(cpuReadData));

		// Full ROM download and VRAM fill
		for (int a = 0; a < romBytes; a++) begin
			writeRom(a, 8'(randomBelow(256)));
		end
		for (int a = 0; a < memMapPkg::vramBytes; a++) begin
			writeVram(a, 8'(randomBelow(256)));
		end

		// Random byte writes with readback, then random reads
		for (int n = 0; n < randomWrites; n++) begin
			addr = randomBelow(memMapPkg::vramBytes);
			writeVram(addr, 8'(randomBelow(256)));
			readCheck("vram readback", addr, vramModel[addr]);
		end
		for (int n = 0; n < randomReads; n++) begin
			addr = randomBelow(memMapPkg::vramBytes);
			readCheck("vram random read", addr, vramModel[addr]);
		end

		// Status and unmapped space
		readCheck("status idle", int'(memMapPkg::statusAddr), 8'h00);
		for (int n = 0; n < unmappedReads; n++) begin
			addr = int'(memMapPkg::statusAddr) + 1 + randomBelow(12'h7FF);
			readCheck("unmapped read", addr, memMapPkg::unmappedData);
		end

		// Render, scan, then scan again for cleared entries
		line = 8'(randomBelow(256));
		startRender(line);
		readCheck("status busy", int'(memMapPkg::statusAddr), 8'h01);
		waitDone("first render");
		readCheck("status after render", int'(memMapPkg::statusAddr), 8'h00);
		scanLine("render scan", line, 1'b0);
		scanLine("cleared scan", line, 1'b1);

		// Second start while busy must be dropped
		line = 8'(randomBelow(256));
		startCount = doneCount;
		startRender(line);
		repeat (3) @(negedge clk0);
		startRender(line ^ 8'h5A);
		waitDone("ignored start render");
		repeat (20) @(negedge clk0);
		checkValue("renderDone pulses", 16'h1, 16'(doneCount - startCount));
		scanLine("ignored start scan", line, 1'b0);

		// Invert the ROM rows used by one line, then render it
		line = 8'(randomBelow(256));
		for (int c = 0; c < videoPkg::tilesPerRow; c++) begin
			word = int'(line[7:3]) * videoPkg::tilesPerRow + c;
			addr = int'(vramModel[2 * word]) * videoPkg::tileSize + int'(line[2:0]);
			writeRom(addr, ~romModel[addr]);
		end
		startRender(line);
		waitDone("patched render");
		scanLine("patched scan", line, 1'b0);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog sized from render and bus cycle counts
	initial begin
		repeat (watchdogCycles) @(posedge clk0);
		$display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: videoMemTop.sv
// Video memory subsystem top

`timescale 1ns/1ps

module videoMemTop (
	input  logic                                 clk0,
	input  logic                                 reset,
	input  logic [memMapPkg::cpuAddrWidth-1:0]   cpuAddr,
	input  logic [memMapPkg::dataWidth-1:0]      cpuWriteData,
	input  logic                                 cpuWrite,
	input  logic                                 cpuRead,
	output logic [memMapPkg::dataWidth-1:0]      cpuReadData,
	input  logic [memMapPkg::romAddrWidth-1:0]   romAddr,
	input  logic [memMapPkg::dataWidth-1:0]      romData,
	input  logic                                 romWrite,
	input  logic                                 lineStart,
	input  logic [videoPkg::lineNumberWidth-1:0] lineNumber,
	output logic                                 busy,
	output logic                                 renderDone,
	input  logic [videoPkg::lineAddrWidth-1:0]   scanAddr,
	input  logic                                 scanRead,
	output logic [videoPkg::pixelWidth-1:0]      scanPixel
);

	logic [memMapPkg::vramWordAddrWidth-1:0] vramWordAddr;
	logic [memMapPkg::vramWordWidth-1:0]     vramWord;
	logic [memMapPkg::romAddrWidth-1:0]      tileRomAddr;
	logic [memMapPkg::dataWidth-1:0]         tileRomByte;
	logic [videoPkg::lineAddrWidth-1:0]      pixelAddr;
	logic [videoPkg::pixelWidth-1:0]         pixel;
	logic                                    pixelWrite;

	cpuBusDecoder cpuBusDecoder_inst (
		.clk0         (clk0),
		.reset        (reset),
		.cpuAddr      (cpuAddr),
		.cpuWriteData (cpuWriteData),
		.cpuWrite     (cpuWrite),
		.cpuRead      (cpuRead),
		.busy         (busy),
		.wordAddr     (vramWordAddr),
		.wordData     (vramWord),
		.cpuReadData  (cpuReadData)
	);

	// Download port writes, renderer reads
	dualPortRam #(
		.addrWidth (memMapPkg::romAddrWidth)
	) tileRom (
		.clk0       (clk0),
		.aAddr      (romAddr),
		.aWriteData (romData),
		.aWrite     (romWrite),
		.aReadData  (),
		.bAddr      (tileRomAddr),
		.bReadData  (tileRomByte)
	);

	lineRenderer lineRenderer_inst (
		.clk0         (clk0),
		.reset        (reset),
		.lineStart    (lineStart),
		.lineNumber   (lineNumber),
		.vramWordAddr (vramWordAddr),
		.vramWord     (vramWord),
		.romAddr      (tileRomAddr),
		.romByte      (tileRomByte),
		.pixelAddr    (pixelAddr),
		.pixel        (pixel),
		.pixelWrite   (pixelWrite),
		.busy         (busy),
		.renderDone   (renderDone)
	);

	lineBuffer lineBuffer_inst (
		.clk0       (clk0),
		.reset      (reset),
		.writeAddr  (pixelAddr),
		.writePixel (pixel),
		.write      (pixelWrite),
		.scanAddr   (scanAddr),
		.scanRead   (scanRead),
		.scanPixel  (scanPixel)
	);

endmodule

// File: videoMem_sva.sv
// Renderer protocol assertions

`timescale 1ns/1ps

module videoMemSva (
	input logic                              clk0,
	input logic                              reset,
	input logic                              lineStart,
	input logic                              renderDone,
	input logic                              pixelWrite,
	input logic                              busy,
	input logic [videoPkg::lineAddrWidth-1:0] pixelAddr
);

	// ----------------------------------------
	// Renderer rules
	// ----------------------------------------
	doneSinglePulse: assert property (@(posedge clk0) disable iff (reset)
		renderDone |=> !renderDone)
		else $error("renderDone stayed high for more than one cycle");

	// A render, and with it any line buffer write, only begins on lineStart
	writeWhileBusy: assert property (@(posedge clk0) disable iff (reset)
		$rose(busy) |-> $past(lineStart))
		else $error("renderer went busy without a lineStart");

	// Pixels within a tile land on consecutive line addresses
	pixelAddrRange: assert property (@(posedge clk0) disable iff (reset)
		pixelWrite && $past(pixelWrite) |-> pixelAddr == $past(pixelAddr) + 1'b1)
		else $error("pixelAddr did not step to the next pixel of the line");

endmodule

bind lineRenderer videoMemSva videoMemSva_inst (
	.clk0       (clk0),
	.reset      (reset),
	.lineStart  (lineStart),
	.renderDone (renderDone),
	.pixelWrite (pixelWrite),
	.busy       (busy),
	.pixelAddr  (pixelAddr)
);

// File: videoPkg.sv
// Tile and scan line geometry

package videoPkg;

	// ----------------------------------------
	// Tile geometry
	// ----------------------------------------
	localparam int tilesPerRow = 32;
	localparam int tileSize = 8;
	localparam int tileBits = $clog2(tileSize);
	localparam int columnBits = $clog2(tilesPerRow);

	// ----------------------------------------
	// Line and pixel format
	// ----------------------------------------
	localparam int lineLength = 256;
	localparam int lineAddrWidth = 8;
	localparam int lineNumberWidth = 8;

	// Palette sits above the single colour bit
	localparam int paletteWidth = 4;
	localparam int pixelWidth = paletteWidth + 1;

endpackage
